// File: afu_supervisor.f
verilog/afu_error_pkg.sv
verilog/afu_mmio_pkg.sv
verilog/error_control.sv
verilog/done_control.sv
verilog/mmio_regs.sv
verilog/afu_supervisor.sv
tb/afu_supervisor_tb.sv

// File: Bender.yml
package:
  name: afu_supervisor

sources:
  # packages first, the RTL blocks depend on them
  - verilog/afu_error_pkg.sv
  - verilog/afu_mmio_pkg.sv
  - verilog/error_control.sv
  - verilog/done_control.sv
  - verilog/mmio_regs.sv
  - verilog/afu_supervisor.sv
  - target: test
    files:
      - tb/afu_supervisor_tb.sv

// File: tb/afu_supervisor_tb.sv
// afu supervisor testbench: table of host accesses, error injections and completions
`default_nettype none
`timescale 1ns/1ps

module afu_supervisor_tb;

  import afu_error_pkg::*;
  import afu_mmio_pkg::*;

  typedef enum logic [2:0] {op_idle, op_error, op_item, op_write, op_read} op_t;

  // one cycle of stimulus, expected read word checked on the following ack
  typedef struct {
    op_t               kind;
    logic              running;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    error_fields_t     pattern;
    report_word_u      exp_word;
    logic              check_flags;
    logic              exp_pending;
    logic              exp_done;
  } row_t;

  logic                  clock;
  logic                  rst_n;
  logic                  job_running;
  logic [job_err_w-1:0]  job_error;
  logic [cmd_err_w-1:0]  cmd_error;
  logic [rd_err_w-1:0]   rd_error;
  logic                  wr_error;
  logic                  item_done;
  logic                  mmio_valid;
  logic                  mmio_read;
  logic [addr_w-1:0]     mmio_address;
  logic [data_w-1:0]     mmio_write_data;
  logic                  mmio_ack;
  logic [data_w-1:0]     mmio_read_data;
  logic                  error_pending;
  logic                  work_done;

  row_t   stim_q[$];
  bit     table_ready = 1'b0;
  integer seed;
  int     value_errors = 0;
  int     handshake_errors = 0;

  afu_supervisor dut (.*);

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input report_word_u got, input report_word_u exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // table building
  ////////////////////////////////////////

  function automatic row_t make_row(input op_t kind, input logic run,
                                    input logic [addr_w-1:0] addr,
                                    input logic [data_w-1:0] wdata,
                                    input error_fields_t pattern,
                                    input report_word_u exp_word);
    row_t r;
    r.kind        = kind;
    r.running     = run;
    r.addr        = addr;
    r.wdata       = wdata;
    r.pattern     = pattern;
    r.exp_word    = exp_word;
    r.check_flags = 1'b0;
    r.exp_pending = 1'b0;
    r.exp_done    = 1'b0;
    return r;
  endfunction

  // error view: layout straight from the error word fields
  function automatic report_word_u error_expect(input error_fields_t f);
    report_word_u w;
    w            = '0;
    w.error_view = f;
    return w;
  endfunction

  function automatic report_word_u status_expect(input logic run, input logic done,
                                                 input logic [count_w-1:0] count);
    report_word_u w;
    w                     = '0;
    w.status_view.running = run;
    w.status_view.done    = done;
    w.status_view.count   = count;
    return w;
  endfunction

  // job side sources only, access errors come from the DUT itself
  function automatic error_fields_t random_pattern();
    logic [31:0]   v;
    error_fields_t p;
    v         = $random(seed);
    p         = '0;
    p.cmd_err = v[6:0];
    p.rd_err  = v[8:7];
    p.wr_err  = v[9];
    p.job_err = v[11:10];
    return p;
  endfunction

  task automatic add_idle(input logic run);
    stim_q.push_back(make_row(op_idle, run, '0, '0, '0, '0));
  endtask

  task automatic add_error(input logic run, input error_fields_t p);
    stim_q.push_back(make_row(op_error, run, '0, '0, p, '0));
  endtask

  task automatic add_item(input logic run);
    stim_q.push_back(make_row(op_item, run, '0, '0, '0, '0));
  endtask

  // writes ack with zero data
  task automatic add_write(input logic run, input logic [addr_w-1:0] a,
                           input logic [data_w-1:0] d);
    stim_q.push_back(make_row(op_write, run, a, d, '0, '0));
  endtask

  task automatic add_read(input logic run, input logic [addr_w-1:0] a, input report_word_u w);
    stim_q.push_back(make_row(op_read, run, a, '0, '0, w));
  endtask

  // flags as they stand after the edge that opens this row
  task automatic mark_flags(input logic pending, input logic done);
    row_t r;
    r             = stim_q.pop_back();
    r.check_flags = 1'b1;
    r.exp_pending = pending;
    r.exp_done    = done;
    stim_q.push_back(r);
  endtask

  task automatic build_table();
    error_fields_t a;
    error_fields_t b;
    error_fields_t acc;
    error_fields_t p;
    error_fields_t job_side;
    seed = 32'hef9e;
    // sticky errors, two fixed patterns
    a         = '0;
    a.job_err = 2'b01;
    a.cmd_err = 7'h05;
    b         = '0;
    b.rd_err  = 2'b10;
    b.wr_err  = 1'b1;
    add_idle(1'b1);
    mark_flags(1'b0, 1'b0);
    add_error(1'b1, a);
    add_error(1'b1, b);
    add_idle(1'b1);
    mark_flags(1'b1, 1'b0);
    add_read(1'b1, reg_error, error_expect(error_fields_t'(a | b)));
    add_idle(1'b1);
    add_read(1'b1, reg_error, '0);
    mark_flags(1'b0, 1'b0);
    // random patterns, OR-ed here
    acc = '0;
    repeat (4) begin
      p   = random_pattern();
      acc = error_fields_t'(acc | p);
      add_error(1'b1, p);
    end
    add_idle(1'b1);
    mark_flags(acc != '0, 1'b0);
    add_read(1'b1, reg_error, error_expect(acc));
    // nothing counts with the job stopped
    job_side         = '0;
    job_side.job_err = '1;
    job_side.cmd_err = '1;
    job_side.rd_err  = '1;
    job_side.wr_err  = 1'b1;
    add_error(1'b0, job_side);
    add_item(1'b0);
    add_item(1'b0);
    add_idle(1'b0);
    add_read(1'b0, reg_error, '0);
    mark_flags(1'b0, 1'b0);
    add_read(1'b0, reg_status, status_expect(1'b0, 1'b0, 32'd0));
    // completion against a total of 3
    add_write(1'b1, reg_total, 64'd3);
    add_item(1'b1);
    add_item(1'b1);
    add_item(1'b1);
    add_idle(1'b1);
    mark_flags(1'b0, 1'b0);
    add_read(1'b1, reg_status, status_expect(1'b1, 1'b1, 32'd3));
    mark_flags(1'b0, 1'b1);
    add_idle(1'b1);
    add_idle(1'b1);
    add_read(1'b1, reg_status, status_expect(1'b1, 1'b0, 32'd0));
    mark_flags(1'b0, 1'b0);
    // total reads back its low half
    add_write(1'b0, reg_total, 64'h5a5a_0123_89ab_cdef);
    add_read(1'b0, reg_total, 64'h0000_0000_89ab_cdef);
    // access errors, recorded with the job stopped
    p          = '0;
    p.mmio_err = 2'b11;
    add_read(1'b0, 4'd7, '0);
    add_write(1'b0, reg_status, '1);
    add_idle(1'b0);
    mark_flags(1'b1, 1'b0);
    add_read(1'b0, reg_error, error_expect(p));
    add_read(1'b0, reg_status, status_expect(1'b0, 1'b0, 32'd0));
    add_idle(1'b0);
    add_read(1'b0, reg_error, '0);
    mark_flags(1'b0, 1'b0);
  endtask

  function automatic logic is_access(input op_t kind);
    return (kind == op_write) || (kind == op_read);
  endfunction

  // every input set each cycle, strobes drop on their own
  task automatic apply_row(input row_t r);
    job_running     <= r.running;
    job_error       <= (r.kind == op_error) ? r.pattern.job_err : '0;
    cmd_error       <= (r.kind == op_error) ? r.pattern.cmd_err : '0;
    rd_error        <= (r.kind == op_error) ? r.pattern.rd_err : '0;
    wr_error        <= (r.kind == op_error) ? r.pattern.wr_err : 1'b0;
    item_done       <= (r.kind == op_item);
    mmio_valid      <= is_access(r.kind);
    mmio_read       <= (r.kind == op_read);
    mmio_address    <= r.addr;
    mmio_write_data <= r.wdata;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int           n;
    report_word_u got;
    rst_n           = 1'b0;
    job_running     = 1'b0;
    job_error       = '0;
    cmd_error       = '0;
    rd_error        = '0;
    wr_error        = 1'b0;
    item_done       = 1'b0;
    mmio_valid      = 1'b0;
    mmio_read       = 1'b0;
    mmio_address    = '0;
    mmio_write_data = '0;
    build_table();
    n           = stim_q.size();
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    // one extra cycle to catch the last ack
    for (int i = 0; i <= n; i++) begin
      @(posedge clock);
      if (i < n) begin
        apply_row(stim_q[i]);
      end else begin
        apply_row(make_row(op_idle, 1'b0, '0, '0, '0, '0));
      end
      @(negedge clock);
      if (i > 0 && is_access(stim_q[i-1].kind)) begin
        if (mmio_ack !== 1'b1) begin
          handshake_errors++;
          $display("no register ack at %0t for the access in row %0d", $time, i - 1);
        end else begin
          got = mmio_read_data;
          check_word("mmio_read_data", got, stim_q[i-1].exp_word);
        end
      end else if (mmio_ack !== 1'b0) begin
        handshake_errors++;
        $display("register ack at %0t with no access in the cycle before", $time);
      end
      if (i < n && stim_q[i].check_flags) begin
        check_flag("error_pending", error_pending, stim_q[i].exp_pending);
        check_flag("work_done", work_done, stim_q[i].exp_done);
      end
    end
    $display("errors: %0d value, %0d handshake, over %0d rows", value_errors,
             handshake_errors, n);
    if (value_errors == 0 && handshake_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // four times the table length in cycles, plus margin
  initial begin
    wait (table_ready);
    #(stim_q.size() * 32 + 200);
    $display("timeout: the stimulus table did not finish within the watchdog limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule : afu_supervisor_tb

`default_nettype wire

// File: verilog/afu_supervisor.sv
// afu job supervisor top: error collector, completion tracker and host registers
`default_nettype none
`timescale 1ns/1ps

module afu_supervisor (
  input  logic                                clock,
  input  logic                                rst_n,
  input  logic                                job_running,
  input  logic [afu_error_pkg::job_err_w-1:0] job_error,
  input  logic [afu_error_pkg::cmd_err_w-1:0] cmd_error,
  input  logic [afu_error_pkg::rd_err_w-1:0]  rd_error,
  input  logic                                wr_error,
  input  logic                                item_done,
  input  logic                                mmio_valid,
  input  logic                                mmio_read,
  input  logic [afu_mmio_pkg::addr_w-1:0]     mmio_address,
  input  logic [afu_mmio_pkg::data_w-1:0]     mmio_write_data,
  output logic                                mmio_ack,
  output logic [afu_mmio_pkg::data_w-1:0]     mmio_read_data,
  output logic                                error_pending,
  output logic                                work_done
);

  import afu_error_pkg::*;
  import afu_mmio_pkg::*;

  // between the side blocks and the register block
  error_fields_t          error_word;
  logic [mmio_err_w-1:0]  mmio_error;
  logic                   error_read_ack;
  logic [count_w-1:0]     done_count;
  logic [count_w-1:0]     work_total;
  logic                   running_flag;
  logic                   status_read_ack;

  ////////////////////////////////////////
  // error collector
  ////////////////////////////////////////

  error_control u_error_control (
    .clock          (clock),
    .rst_n          (rst_n),
    .job_running    (job_running),
    .job_error      (job_error),
    .cmd_error      (cmd_error),
    .rd_error       (rd_error),
    .wr_error       (wr_error),
    .mmio_error     (mmio_error),
    .error_read_ack (error_read_ack),
    .error_word     (error_word),
    .error_pending  (error_pending)
  );

  ////////////////////////////////////////
  // completion tracker
  ////////////////////////////////////////

  done_control u_done_control (
    .clock           (clock),
    .rst_n           (rst_n),
    .job_running     (job_running),
    .item_done       (item_done),
    .work_total      (work_total),
    .status_read_ack (status_read_ack),
    .done_count      (done_count),
    .work_done       (work_done),
    .running_flag    (running_flag)
  );

  ////////////////////////////////////////
  // host registers
  ////////////////////////////////////////

  mmio_regs u_mmio_regs (
    .clock           (clock),
    .rst_n           (rst_n),
    .mmio_valid      (mmio_valid),
    .mmio_read       (mmio_read),
    .mmio_address    (mmio_address),
    .mmio_write_data (mmio_write_data),
    .error_word      (error_word),
    .done_count      (done_count),
    .work_done       (work_done),
    .running_flag    (running_flag),
    .mmio_ack        (mmio_ack),
    .mmio_read_data  (mmio_read_data),
    .work_total      (work_total),
    .error_read_ack  (error_read_ack),
    .status_read_ack (status_read_ack),
    .mmio_error      (mmio_error)
  );

endmodule : afu_supervisor

`default_nettype wire

// File: verilog/mmio_regs.sv
// host register block decoding accesses and raising acks, read data and access errors
`default_nettype none
`timescale 1ns/1ps

module mmio_regs (
  input  logic                                 clock,
  input  logic                                 rst_n,
  input  logic                                 mmio_valid,
  input  logic                                 mmio_read,
  input  logic [afu_mmio_pkg::addr_w-1:0]      mmio_address,
  input  logic [afu_mmio_pkg::data_w-1:0]      mmio_write_data,
  input  afu_error_pkg::error_fields_t         error_word,
  input  logic [afu_mmio_pkg::count_w-1:0]     done_count,
  input  logic                                 work_done,
  input  logic                                 running_flag,
  output logic                                 mmio_ack,
  output logic [afu_mmio_pkg::data_w-1:0]      mmio_read_data,
  output logic [afu_mmio_pkg::count_w-1:0]     work_total,
  output logic                                 error_read_ack,
  output logic                                 status_read_ack,
  output logic [afu_error_pkg::mmio_err_w-1:0] mmio_error
);

  import afu_mmio_pkg::*;

  // request decode
  logic known_addr;
  logic read_only;
  logic bad_addr;
  logic wr_total;

  // request held for the ack cycle
  logic [addr_w-1:0] req_addr;
  logic              req_read;

  // read word in error or status view
  report_word_u read_word;

  ////////////////////////////////////////
  // strobe decode
  ////////////////////////////////////////

  assign known_addr = (mmio_address == reg_error) || (mmio_address == reg_status) ||
                      (mmio_address == reg_total);
  assign bad_addr   = mmio_valid && !known_addr;
  assign read_only  = mmio_valid && !mmio_read &&
                      ((mmio_address == reg_error) || (mmio_address == reg_status));
  assign wr_total   = mmio_valid && !mmio_read && (mmio_address == reg_total);

  // ack and side pulses one cycle after the strobe
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mmio_ack        <= 1'b0;
      error_read_ack  <= 1'b0;
      status_read_ack <= 1'b0;
      mmio_error      <= '0;
      work_total      <= '0;
    end else begin
      mmio_ack        <= mmio_valid;
      error_read_ack  <= mmio_valid && mmio_read && (mmio_address == reg_error);
      // status ack only once done is up
      status_read_ack <= mmio_valid && mmio_read && (mmio_address == reg_status) && work_done;
      mmio_error      <= {read_only, bad_addr};
      // new total visible right after this edge
      if (wr_total) begin
        work_total <= mmio_write_data[count_w-1:0];
      end
    end
  end

  // address and direction for the ack cycle
  always_ff @(posedge clock) begin
    if (mmio_valid) begin
      req_addr <= mmio_address;
      req_read <= mmio_read;
    end
  end

  ////////////////////////////////////////
  // read data assembly
  ////////////////////////////////////////

  // live word in the ack cycle
  // error clear lands on the next edge
  always_comb begin
    read_word = '0;
    if (mmio_ack && req_read) begin
      case (req_addr)
        reg_error: read_word.error_view = error_word;
        reg_status: begin
          read_word.status_view.running = running_flag;
          read_word.status_view.done    = work_done;
          read_word.status_view.count   = done_count;
        end
        reg_total: read_word = {{(data_w-count_w){1'b0}}, work_total};
        // bad address reads zero
        default: read_word = '0;
      endcase
    end
  end

  assign mmio_read_data = read_word;

  // no ack without a strobe the cycle before
  a_ack_after_valid : assert property (@(posedge clock) disable iff (!rst_n)
    mmio_ack |-> $past(mmio_valid));

endmodule : mmio_regs

`default_nettype wire

// File: verilog/done_control.sv
// completion tracker: counts finished work items against the host total, raises done
`default_nettype none
`timescale 1ns/1ps

module done_control (
  input  logic                             clock,
  input  logic                             rst_n,
  input  logic                             job_running,
  input  logic                             item_done,
  input  logic [afu_mmio_pkg::count_w-1:0] work_total,
  input  logic                             status_read_ack,
  output logic [afu_mmio_pkg::count_w-1:0] done_count,
  output logic                             work_done,
  output logic                             running_flag
);

  import afu_mmio_pkg::*;

  // total set and count reached it
  logic at_total;
  // ack seen last cycle, clear on this edge
  logic clear_pending;

  assign at_total = (work_total != '0) && (done_count >= work_total);

  ////////////////////////////////////////
  // item counter and done flag
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      done_count    <= '0;
      work_done     <= 1'b0;
      clear_pending <= 1'b0;
    end else begin
      clear_pending <= status_read_ack;
      if (clear_pending) begin
        // self clear one cycle after the host saw done
        done_count <= '0;
        work_done  <= 1'b0;
      end else begin
        // holds at the total until cleared
        if (item_done && job_running && !at_total) begin
          done_count <= done_count + count_w'(1);
        end
        work_done <= at_total;
      end
    end
  end

  // job enable, one cycle late
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      running_flag <= 1'b0;
    end else begin
      running_flag <= job_running;
    end
  end

  // count against the total held in the register block
  a_count_le_total : assert property (@(posedge clock) disable iff (!rst_n)
    (work_total != '0) |-> (done_count <= work_total));

endmodule : done_control

`default_nettype wire

// File: verilog/error_control.sv
// error collector: sticky error bits gathered while the job runs, cleared on host read
`default_nettype none
`timescale 1ns/1ps

module error_control (
  input  logic                                 clock,
  input  logic                                 rst_n,
  input  logic                                 job_running,
  input  logic [afu_error_pkg::job_err_w-1:0]  job_error,
  input  logic [afu_error_pkg::cmd_err_w-1:0]  cmd_error,
  input  logic [afu_error_pkg::rd_err_w-1:0]   rd_error,
  input  logic                                 wr_error,
  input  logic [afu_error_pkg::mmio_err_w-1:0] mmio_error,
  input  logic                                 error_read_ack,
  output afu_error_pkg::error_fields_t         error_word,
  output logic                                 error_pending
);

  import afu_error_pkg::*;

  // bits arriving this cycle
  error_fields_t incoming;
  // word after this edge
  error_fields_t next_word;

  ////////////////////////////////////////
  // incoming error bits
  ////////////////////////////////////////

  always_comb begin
    incoming = '0;
    // job side sources only count while running
    if (job_running) begin
      incoming.job_err = job_error;
      incoming.cmd_err = cmd_error;
      incoming.rd_err  = rd_error;
      incoming.wr_err  = wr_error;
    end
    // host access errors are always kept
    incoming.mmio_err = mmio_error;
  end

  // read ack clears, set wins over clear
  always_comb begin
    next_word = error_read_ack ? '0 : error_word;
    next_word = next_word | incoming;
  end

  ////////////////////////////////////////
  // sticky word and pending flag
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      error_word    <= '0;
      error_pending <= 1'b0;
    end else begin
      error_word    <= next_word;
      // tracks the word on the same edge
      error_pending <= |next_word;
    end
  end

  // reserved field never picks up a bit
  a_reserved_zero : assert property (@(posedge clock) disable iff (!rst_n)
    error_word.reserved == '0);

endmodule : error_control

`default_nettype wire

// File: verilog/afu_mmio_pkg.sv
// afu mmio package: register map, widths and the two-view report word
`default_nettype none

package afu_mmio_pkg;

  ////////////////////////////////////////
  // register bus widths
  ////////////////////////////////////////

  // host register data width
  localparam int data_w  = 64;

  // host register address width
  localparam int addr_w  = 4;

  // completion count and total width
  localparam int count_w = 32;

  // reserved top of the status word
  localparam int stat_rsvd_w = data_w - 2 - count_w;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // sticky error word, clear on read
  localparam logic [addr_w-1:0] reg_error  = 4'd0;
  // running, done and count, read only
  localparam logic [addr_w-1:0] reg_status = 4'd1;
  // work item total, read write
  localparam logic [addr_w-1:0] reg_total  = 4'd2;

  ////////////////////////////////////////
  // report word views
  ////////////////////////////////////////

  // msb down: reserved, running, done, completed count
  typedef struct packed {
    logic [stat_rsvd_w-1:0] reserved;
    logic                   running;
    logic                   done;
    logic [count_w-1:0]     count;
  } status_fields_t;

  // one read word, decoded as error view or status view
  typedef union packed {
    afu_error_pkg::error_fields_t error_view;
    status_fields_t               status_view;
  } report_word_u;

endpackage : afu_mmio_pkg

`default_nettype wire

// File: verilog/afu_error_pkg.sv
// afu error package: error source widths and the sticky error word layout
`default_nettype none

package afu_error_pkg;

  ////////////////////////////////////////
  // error source widths
  ////////////////////////////////////////

  // command response error field
  localparam int cmd_err_w  = 7;

  // data read error field
  localparam int rd_err_w   = 2;

  // job error field
  localparam int job_err_w  = 2;

  // register access errors
  // bit 0 bad address, bit 1 write to a read-only register
  localparam int mmio_err_w = 2;

  // reserved top of the error word
  localparam int err_rsvd_w = 64 - job_err_w - mmio_err_w - 1 - rd_err_w - cmd_err_w;

  ////////////////////////////////////////
  // error word layout
  ////////////////////////////////////////

  // msb down: reserved, job, mmio, write, read, command
  typedef struct packed {
    logic [err_rsvd_w-1:0] reserved;
    logic [job_err_w-1:0]  job_err;
    logic [mmio_err_w-1:0] mmio_err;
    logic                  wr_err;
    logic [rd_err_w-1:0]   rd_err;
    logic [cmd_err_w-1:0]  cmd_err;
  } error_fields_t;

endpackage : afu_error_pkg

`default_nettype wire
